/* rtl/gs_pkg.sv */
/*
  shared widths, address map and FSM states for the scatter tile
  referenced by scoped names from every RTL block
*/
package gs_pkg;

  // word and mask widths
  localparam int data_width_lp = 32;
  typedef logic [data_width_lp-1:0]   data_t;
  typedef logic [data_width_lp/8-1:0] mask_t;

  // tile-local addressing
  typedef logic [11:0] epa_t;
  typedef logic [9:0]  dmem_addr_t;
  localparam int dmem_els_lp = 1024;
  typedef logic [10:0] count_t;

  typedef logic [3:0] x_cord_t;
  typedef logic [3:0] y_cord_t;

  // outstanding remote stores
  typedef logic [5:0] credit_t;
  localparam int max_credits_lp = 32;

  // config registers, write only
  localparam epa_t csr_run_addr_lp    = 12'h000;
  localparam epa_t csr_len_addr_lp    = 12'h001;
  localparam epa_t csr_stride_addr_lp = 12'h002;
  localparam epa_t csr_base_addr_lp   = 12'h003;

  // data memory window 0x400..0x7ff
  localparam epa_t dmem_base_lp = 12'h400;

  localparam data_t invalid_data_lp = 32'hdeadbeef;
  localparam data_t wakeup_data_lp  = 32'd1;

  // RUN data bits 13:2 hold the wake-up word address
  localparam int wakeup_lsb_lp = 2;

  // target address split
  localparam int eva_epa_lsb_lp = 0;
  localparam int eva_x_lsb_lp   = 12;
  localparam int eva_y_lsb_lp   = 16;

  typedef enum logic [1:0] {
    IDLE,
    SCATTER,
    WAKEUP
  } gs_state_e;

endpackage

/* rtl/gs_csr.sv */
/*
  request decoder for the tile: config registers, dmem host accesses,
  run launch and the one-cycle-late response
*/
`timescale 1ns/100ps

module gs_csr (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 in_v_i,
  input  logic                 in_we_i,
  input  gs_pkg::epa_t         in_addr_i,
  input  gs_pkg::data_t        in_data_i,
  input  gs_pkg::mask_t        in_mask_i,
  input  gs_pkg::x_cord_t      in_src_x_i,
  input  gs_pkg::y_cord_t      in_src_y_i,
  input  logic                 busy_i,
  input  gs_pkg::data_t        dmem_data_i,
  output logic                 in_yumi_o,
  output logic                 returning_v_o,
  output gs_pkg::data_t        returning_data_o,
  output logic                 dmem_v_o,
  output logic                 dmem_w_o,
  output gs_pkg::dmem_addr_t   dmem_addr_o,
  output gs_pkg::mask_t        dmem_mask_o,
  output gs_pkg::data_t        dmem_wdata_o,
  output logic                 run_o,
  output gs_pkg::epa_t         wakeup_addr_o,
  output gs_pkg::x_cord_t      src_x_o,
  output gs_pkg::y_cord_t      src_y_o,
  output gs_pkg::dmem_addr_t   len_o,
  output gs_pkg::dmem_addr_t   stride_o,
  output gs_pkg::data_t        base_o
);

  logic is_dmem;
  logic run_write;
  logic resp_v_r;
  logic resp_dmem_r;
  logic resp_invalid_r;

  // every request is taken while the engine is idle
  assign in_yumi_o = in_v_i & ~busy_i;

  // upper address bits select the dmem window
  assign is_dmem = (in_addr_i & ~gs_pkg::epa_t'(gs_pkg::dmem_els_lp - 1)) == gs_pkg::dmem_base_lp;
  assign run_write = in_yumi_o & in_we_i & (in_addr_i == gs_pkg::csr_run_addr_lp);

  // host side of the data memory
  assign dmem_v_o     = in_yumi_o & is_dmem;
  assign dmem_w_o     = in_we_i;
  assign dmem_addr_o  = gs_pkg::dmem_addr_t'(in_addr_i);
  assign dmem_mask_o  = in_mask_i;
  assign dmem_wdata_o = in_data_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      len_o          <= '0;
      stride_o       <= '0;
      base_o         <= '0;
      run_o          <= 1'b0;
      resp_v_r       <= 1'b0;
      resp_dmem_r    <= 1'b0;
      resp_invalid_r <= 1'b0;
    end else begin
      run_o          <= run_write;
      resp_v_r       <= in_yumi_o;
      resp_dmem_r    <= in_yumi_o & ~in_we_i & is_dmem;
      resp_invalid_r <= in_yumi_o & ~in_we_i & ~is_dmem;
      if (in_yumi_o && in_we_i) begin
        if (in_addr_i == gs_pkg::csr_len_addr_lp) len_o <= gs_pkg::dmem_addr_t'(in_data_i);
        if (in_addr_i == gs_pkg::csr_stride_addr_lp) stride_o <= gs_pkg::dmem_addr_t'(in_data_i);
        if (in_addr_i == gs_pkg::csr_base_addr_lp) base_o <= in_data_i;
      end
    end
  end

  // caller identity for the wake-up store
  always_ff @(posedge clk_i) begin
    if (run_write) begin
      src_x_o       <= in_src_x_i;
      src_y_o       <= in_src_y_i;
      wakeup_addr_o <= in_data_i[gs_pkg::wakeup_lsb_lp +: $bits(gs_pkg::epa_t)];
    end
  end

  assign returning_v_o = resp_v_r;

  always_comb begin
    if (resp_dmem_r) begin
      returning_data_o = dmem_data_i;
    end else if (resp_invalid_r) begin
      returning_data_o = gs_pkg::invalid_data_lp;
    end else begin
      returning_data_o = '0;
    end
  end

  // engine must report busy right after the RUN write
  a_run_busy: assert property (@(posedge clk_i) disable iff (reset_i) run_write |=> busy_i);

endmodule

/* rtl/gs_dmem.sv */
/*
  1024-word synchronous data memory with byte write mask
  engine reads take the single port ahead of host accesses
*/
`timescale 1ns/100ps

module gs_dmem (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                host_v_i,
  input  logic                host_w_i,
  input  gs_pkg::dmem_addr_t  host_addr_i,
  input  gs_pkg::mask_t       host_mask_i,
  input  gs_pkg::data_t       host_data_i,
  input  logic                eng_v_i,
  input  gs_pkg::dmem_addr_t  eng_addr_i,
  output gs_pkg::data_t       data_o
);

  gs_pkg::data_t      mem [gs_pkg::dmem_els_lp];
  gs_pkg::data_t      data_r;
  gs_pkg::dmem_addr_t addr;
  logic               v;
  logic               w;

  // port select
  assign v    = eng_v_i | host_v_i;
  assign w    = ~eng_v_i & host_w_i;
  assign addr = eng_v_i ? eng_addr_i : host_addr_i;

  always_ff @(posedge clk_i) begin
    if (v && w) begin
      for (int b = 0; b < $bits(gs_pkg::mask_t); b++) begin
        if (host_mask_i[b]) mem[addr][8*b +: 8] <= host_data_i[8*b +: 8];
      end
    end else if (v) begin
      data_r <= mem[addr];
    end
  end

  // output holds the last read word
  assign data_o = data_r;

  a_one_port: assert property (@(posedge clk_i) disable iff (reset_i) !(host_v_i && eng_v_i));

endmodule

/* rtl/gs_scatter_engine.sv */
/*
  scatter FSM: streams dmem words 0..len as remote stores under a credit limit,
  then sends the wake-up store once every credit has returned
*/
`timescale 1ns/100ps

module gs_scatter_engine (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                run_i,
  input  gs_pkg::epa_t        wakeup_addr_i,
  input  gs_pkg::x_cord_t     src_x_i,
  input  gs_pkg::y_cord_t     src_y_i,
  input  gs_pkg::dmem_addr_t  len_i,
  input  gs_pkg::dmem_addr_t  stride_i,
  input  gs_pkg::data_t       base_i,
  input  gs_pkg::data_t       dmem_data_i,
  input  logic                out_ready_i,
  input  logic                out_returned_i,
  output logic                busy_o,
  output logic                dmem_v_o,
  output gs_pkg::dmem_addr_t  dmem_addr_o,
  output logic                out_v_o,
  output gs_pkg::epa_t        out_addr_o,
  output gs_pkg::x_cord_t     out_x_o,
  output gs_pkg::y_cord_t     out_y_o,
  output gs_pkg::data_t       out_data_o
);

  gs_pkg::gs_state_e state_r;
  gs_pkg::gs_state_e state_n;
  gs_pkg::count_t    count_r;
  gs_pkg::count_t    count_n;
  gs_pkg::credit_t   credit_r;
  gs_pkg::data_t     eva;
  logic              credits_full;
  logic              credits_empty;
  logic              last_word;
  logic              xfer;

  assign credits_full  = credit_r == gs_pkg::credit_t'(gs_pkg::max_credits_lp);
  assign credits_empty = credit_r == '0;
  assign last_word     = count_r == gs_pkg::count_t'(len_i);

  // word-granular target address
  assign eva = base_i + gs_pkg::data_t'(count_r) * gs_pkg::data_t'(stride_i);

  // run pulse counts as busy so the next request is refused
  assign busy_o = run_i | (state_r != gs_pkg::IDLE);

  assign out_v_o = ((state_r == gs_pkg::SCATTER) & ~credits_full)
                 | ((state_r == gs_pkg::WAKEUP) & credits_empty);
  assign xfer = out_v_o & out_ready_i;

  always_comb begin
    if (state_r == gs_pkg::WAKEUP) begin
      out_addr_o = wakeup_addr_i;
      out_x_o    = src_x_i;
      out_y_o    = src_y_i;
      out_data_o = gs_pkg::wakeup_data_lp;
    end else begin
      out_addr_o = eva[gs_pkg::eva_epa_lsb_lp +: $bits(gs_pkg::epa_t)];
      out_x_o    = eva[gs_pkg::eva_x_lsb_lp +: $bits(gs_pkg::x_cord_t)];
      out_y_o    = eva[gs_pkg::eva_y_lsb_lp +: $bits(gs_pkg::y_cord_t)];
      out_data_o = dmem_data_i;
    end
  end

  always_comb begin
    state_n     = state_r;
    count_n     = count_r;
    dmem_v_o    = 1'b0;
    dmem_addr_o = gs_pkg::dmem_addr_t'(count_r);
    case (state_r)
      gs_pkg::IDLE: begin
        // fetch word 0 so it is ready on entry
        if (run_i) begin
          dmem_v_o    = 1'b1;
          dmem_addr_o = '0;
          count_n     = '0;
          state_n     = gs_pkg::SCATTER;
        end
      end
      gs_pkg::SCATTER: begin
        if (xfer) begin
          if (last_word) begin
            state_n = gs_pkg::WAKEUP;
          end else begin
            count_n     = count_r + 1'b1;
            dmem_v_o    = 1'b1;
            dmem_addr_o = gs_pkg::dmem_addr_t'(count_n);
          end
        end
      end
      gs_pkg::WAKEUP: begin
        if (xfer) state_n = gs_pkg::IDLE;
      end
      default: state_n = gs_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= gs_pkg::IDLE;
      count_r  <= '0;
      credit_r <= '0;
    end else begin
      state_r  <= state_n;
      count_r  <= count_n;
      // send and return may land together
      credit_r <= credit_r + gs_pkg::credit_t'(xfer) - gs_pkg::credit_t'(out_returned_i);
    end
  end

  a_credit_max: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_r <= gs_pkg::credit_t'(gs_pkg::max_credits_lp));

  // a return needs an outstanding store
  a_credit_under: assert property (@(posedge clk_i) disable iff (reset_i)
    out_returned_i |-> !credits_empty);

endmodule

/* rtl/gs_tile.sv */
/*
  scatter tile top: request decoder, data memory and scatter engine
  the requester-facing and outbound store ports are loose signals
*/
`timescale 1ns/100ps

module gs_tile (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             in_v_i,
  input  logic             in_we_i,
  input  gs_pkg::epa_t     in_addr_i,
  input  gs_pkg::data_t    in_data_i,
  input  gs_pkg::mask_t    in_mask_i,
  input  gs_pkg::x_cord_t  in_src_x_i,
  input  gs_pkg::y_cord_t  in_src_y_i,
  output logic             in_yumi_o,
  output logic             returning_v_o,
  output gs_pkg::data_t    returning_data_o,
  output logic             out_v_o,
  output gs_pkg::epa_t     out_addr_o,
  output gs_pkg::x_cord_t  out_x_o,
  output gs_pkg::y_cord_t  out_y_o,
  output gs_pkg::data_t    out_data_o,
  input  logic             out_ready_i,
  input  logic             out_returned_i
);

  logic               busy;
  logic               run;
  gs_pkg::epa_t       wakeup_addr;
  gs_pkg::x_cord_t    src_x;
  gs_pkg::y_cord_t    src_y;
  gs_pkg::dmem_addr_t len;
  gs_pkg::dmem_addr_t stride;
  gs_pkg::data_t      base;
  gs_pkg::data_t      dmem_data;
  logic               host_v;
  logic               host_w;
  gs_pkg::dmem_addr_t host_addr;
  gs_pkg::mask_t      host_mask;
  gs_pkg::data_t      host_wdata;
  logic               eng_v;
  gs_pkg::dmem_addr_t eng_addr;

  gs_csr csr (
    .clk_i(clk_i), .reset_i(reset_i),
    .in_v_i(in_v_i), .in_we_i(in_we_i), .in_addr_i(in_addr_i),
    .in_data_i(in_data_i), .in_mask_i(in_mask_i),
    .in_src_x_i(in_src_x_i), .in_src_y_i(in_src_y_i),
    .busy_i(busy), .dmem_data_i(dmem_data),
    .in_yumi_o(in_yumi_o),
    .returning_v_o(returning_v_o), .returning_data_o(returning_data_o),
    .dmem_v_o(host_v), .dmem_w_o(host_w), .dmem_addr_o(host_addr),
    .dmem_mask_o(host_mask), .dmem_wdata_o(host_wdata),
    .run_o(run), .wakeup_addr_o(wakeup_addr), .src_x_o(src_x), .src_y_o(src_y),
    .len_o(len), .stride_o(stride), .base_o(base)
  );

  gs_dmem dmem (
    .clk_i(clk_i), .reset_i(reset_i),
    .host_v_i(host_v), .host_w_i(host_w), .host_addr_i(host_addr),
    .host_mask_i(host_mask), .host_data_i(host_wdata),
    .eng_v_i(eng_v), .eng_addr_i(eng_addr),
    .data_o(dmem_data)
  );

  gs_scatter_engine engine (
    .clk_i(clk_i), .reset_i(reset_i),
    .run_i(run), .wakeup_addr_i(wakeup_addr), .src_x_i(src_x), .src_y_i(src_y),
    .len_i(len), .stride_i(stride), .base_i(base), .dmem_data_i(dmem_data),
    .out_ready_i(out_ready_i), .out_returned_i(out_returned_i),
    .busy_o(busy), .dmem_v_o(eng_v), .dmem_addr_o(eng_addr),
    .out_v_o(out_v_o), .out_addr_o(out_addr_o), .out_x_o(out_x_o),
    .out_y_o(out_y_o), .out_data_o(out_data_o)
  );

endmodule

/* verification/gs_tile_tb.sv */
/*
  testbench for the scatter tile: host accesses, config writes and two scatter runs
  against a reference model, with a store sink that returns credits late
*/
`timescale 1ns/100ps

module gs_tile_tb;

  // the tests take about 3000 cycles
  localparam int timeout_cycles_lp = 20000;

  logic            clk_i;
  logic            reset_i;
  logic            in_v_i;
  logic            in_we_i;
  gs_pkg::epa_t    in_addr_i;
  gs_pkg::data_t   in_data_i;
  gs_pkg::mask_t   in_mask_i;
  gs_pkg::x_cord_t in_src_x_i;
  gs_pkg::y_cord_t in_src_y_i;
  logic            in_yumi_o;
  logic            returning_v_o;
  gs_pkg::data_t   returning_data_o;
  logic            out_v_o;
  gs_pkg::epa_t    out_addr_o;
  gs_pkg::x_cord_t out_x_o;
  gs_pkg::y_cord_t out_y_o;
  gs_pkg::data_t   out_data_o;
  logic            out_ready_i;
  logic            out_returned_i;

  // reference model of the memory and the current run
  gs_pkg::data_t   model_mem [1024];
  gs_pkg::data_t   cfg_base;
  int              cfg_len;
  int              cfg_stride;
  gs_pkg::epa_t    cfg_wake;
  gs_pkg::x_cord_t cfg_x;
  gs_pkg::y_cord_t cfg_y;

  int   cycle;
  int   errors;
  int   store_idx;
  int   outstanding;
  int   wake_cycle;
  logic run_active;
  logic run_done;
  logic hold_credits;
  logic resp_due;
  // cycle at which each outstanding credit may come back
  int   ret_q[$];

  gs_tile uut (.*);

  always #50 clk_i = ~clk_i;

  task automatic stop_on_error(input string msg);
    errors++;
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input gs_pkg::data_t got,
      input gs_pkg::data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_epa(input string name, input gs_pkg::epa_t got, input gs_pkg::epa_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_cord(input string name, input gs_pkg::x_cord_t got,
      input gs_pkg::x_cord_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL at %0t: %s got %0d expected %0d", $time, name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  // expected store for one index: word address base + idx * stride, then field split
  function automatic void ref_store(input int idx, output gs_pkg::epa_t addr,
      output gs_pkg::x_cord_t x, output gs_pkg::y_cord_t y, output gs_pkg::data_t data);
    logic [31:0] eva;
    eva  = cfg_base + 32'(idx) * 32'(cfg_stride);
    addr = eva[11:0];
    x    = eva[15:12];
    y    = eva[19:16];
    data = model_mem[idx];
  endfunction

  // one request, held until accepted; resp is sampled one cycle after acceptance
  task automatic send_req(input logic we, input gs_pkg::epa_t addr, input gs_pkg::data_t data,
      input gs_pkg::mask_t mask, input gs_pkg::x_cord_t x, input gs_pkg::y_cord_t y,
      output gs_pkg::data_t resp);
    @(posedge clk_i);
    #10;
    in_v_i     = 1'b1;
    in_we_i    = we;
    in_addr_i  = addr;
    in_data_i  = data;
    in_mask_i  = mask;
    in_src_x_i = x;
    in_src_y_i = y;
    @(negedge clk_i);
    while (!in_yumi_o) @(negedge clk_i);
    if (run_active && !(run_done && cycle > wake_cycle))
      stop_on_error("request accepted while the engine was still busy");
    @(posedge clk_i);
    #10;
    in_v_i = 1'b0;
    @(negedge clk_i);
    resp = returning_data_o;
  endtask

  task automatic write_mem(input int idx, input gs_pkg::data_t data, input gs_pkg::mask_t mask);
    gs_pkg::data_t resp;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) model_mem[idx][8*b +: 8] = data[8*b +: 8];
    end
    send_req(1'b1, 12'h400 | 12'(idx), data, mask, '0, '0, resp);
    check_data("returning_data_o", resp, 32'h0);
  endtask

  task automatic read_mem(input int idx);
    gs_pkg::data_t resp;
    send_req(1'b0, 12'h400 | 12'(idx), '0, '0, '0, '0, resp);
    check_data("returning_data_o", resp, model_mem[idx]);
  endtask

  task automatic start_run(input int len, input int stride, input gs_pkg::data_t base,
      input gs_pkg::epa_t wake, input gs_pkg::x_cord_t x, input gs_pkg::y_cord_t y);
    gs_pkg::data_t resp;
    cfg_len    = len;
    cfg_stride = stride;
    cfg_base   = base;
    cfg_wake   = wake;
    cfg_x      = x;
    cfg_y      = y;
    send_req(1'b1, 12'h001, 32'(len), 4'hf, '0, '0, resp);
    check_data("returning_data_o", resp, 32'h0);
    send_req(1'b1, 12'h002, 32'(stride), 4'hf, '0, '0, resp);
    check_data("returning_data_o", resp, 32'h0);
    send_req(1'b1, 12'h003, base, 4'hf, '0, '0, resp);
    check_data("returning_data_o", resp, 32'h0);
    store_idx = 0;
    run_done  = 1'b0;
    // junk above bit 13 and in bits 1:0 must be ignored
    send_req(1'b1, 12'h000, {18'h30f5a, wake, 2'b11}, 4'hf, x, y, resp);
    check_data("returning_data_o", resp, 32'h0);
    run_active = 1'b1;
  endtask

  task automatic wait_credits_back();
    while (ret_q.size() != 0 || outstanding != 0) @(posedge clk_i);
  endtask

  always @(posedge clk_i) begin
    cycle++;
    if (cycle > timeout_cycles_lp) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  // store sink: random ready, one credit return per cycle once its delay has passed
  always @(posedge clk_i) begin : store_sink
    int k;
    #10;
    out_ready_i    = ($urandom_range(0, 3) != 0);
    out_returned_i = 1'b0;
    if (!hold_credits) begin
      k = 0;
      while (k < ret_q.size() && ret_q[k] > cycle) k++;
      if (k < ret_q.size()) begin
        out_returned_i = 1'b1;
        ret_q.delete(k);
      end
    end
  end

  // compares responses and every store that transfers at the next edge
  always @(negedge clk_i) begin : compare
    gs_pkg::epa_t    e_addr;
    gs_pkg::x_cord_t e_x;
    gs_pkg::y_cord_t e_y;
    gs_pkg::data_t   e_data;
    logic            xfer;
    if (!reset_i) begin
      check_flag("returning_v_o", returning_v_o, resp_due);
      resp_due = in_v_i && in_yumi_o;
      if (out_v_o && outstanding >= 32) stop_on_error("store offered with no credit left");
      xfer = out_v_o && out_ready_i;
      if (xfer) begin
        if (!run_active || run_done) stop_on_error("store sent outside of a run");
        if (store_idx <= cfg_len) begin
          ref_store(store_idx, e_addr, e_x, e_y, e_data);
          check_epa("out_addr_o", out_addr_o, e_addr);
          check_cord("out_x_o", out_x_o, e_x);
          check_cord("out_y_o", out_y_o, e_y);
          check_data("out_data_o", out_data_o, e_data);
          store_idx++;
        end else begin
          check_epa("out_addr_o", out_addr_o, cfg_wake);
          check_cord("out_x_o", out_x_o, cfg_x);
          check_cord("out_y_o", out_y_o, cfg_y);
          check_data("out_data_o", out_data_o, 32'h1);
          if (outstanding != 0) stop_on_error("wake-up store sent before all credits came back");
          run_done   = 1'b1;
          wake_cycle = cycle;
        end
        ret_q.push_back(cycle + 1 + $urandom_range(0, 7));
      end
      outstanding = outstanding + int'(xfer) - int'(out_returned_i);
    end
  end

  initial begin : main
    gs_pkg::data_t resp;
    int            addr_q[$];
    int            a;
    a = $urandom(16);
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    in_v_i         = 1'b0;
    in_we_i        = 1'b0;
    in_addr_i      = '0;
    in_data_i      = '0;
    in_mask_i      = '0;
    in_src_x_i     = '0;
    in_src_y_i     = '0;
    out_ready_i    = 1'b0;
    out_returned_i = 1'b0;
    cycle          = 0;
    errors         = 0;
    store_idx      = 0;
    outstanding    = 0;
    wake_cycle     = 0;
    run_active     = 1'b0;
    run_done       = 1'b0;
    hold_credits   = 1'b0;
    resp_due       = 1'b0;
    cfg_len        = 0;
    repeat (5) @(posedge clk_i);
    #10;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_flag("in_yumi_o", in_yumi_o, 1'b0);
    check_flag("out_v_o", out_v_o, 1'b0);

    // fill pattern over the whole address, then random masked writes
    for (a = 0; a < 1024; a++) write_mem(a, (32'h9e3779b9 * 32'(a + 1)) ^ 32'(a << 20), 4'hf);
    repeat (100) begin
      a = $urandom_range(0, 1023);
      addr_q.push_back(a);
      write_mem(a, $urandom, 4'($urandom_range(1, 15)));
    end
    foreach (addr_q[i]) read_mem(addr_q[i]);

    // unmapped writes are dropped, unmapped and config reads give the invalid word
    for (a = 0; a < 4; a++) begin
      send_req(1'b1, a == 0 ? 12'h004 : a == 1 ? 12'h3ff : a == 2 ? 12'h800 : 12'hfff,
               $urandom, 4'hf, '0, '0, resp);
      check_data("returning_data_o", resp, 32'h0);
    end
    for (a = 0; a < 8; a++) begin
      send_req(1'b0, a < 4 ? 12'(a) : a == 4 ? 12'h004 : a == 5 ? 12'h3ff : a == 6 ? 12'h800
               : 12'hfff, '0, '0, '0, '0, resp);
      check_data("returning_data_o", resp, 32'hdeadbeef);
    end

    // run 1 stalls at 32 stores until credits are released
    hold_credits = 1'b1;
    start_run(47, 5, 32'h0003_2100, 12'h9c4, 4'd5, 4'd9);
    while (store_idx < 32) @(posedge clk_i);
    repeat (20) @(posedge clk_i);
    if (store_idx != 32) stop_on_error("stores kept flowing with no credit returned");
    hold_credits = 1'b0;
    while (!run_done) @(posedge clk_i);
    run_active = 1'b0;
    wait_credits_back();

    // run 2 crosses x boundaries; a held read waits for the wake-up store
    start_run(20, 10'h2f1, 32'h0001_5f80, 12'h35a, 4'd14, 4'd1);
    send_req(1'b0, 12'h405, '0, '0, '0, '0, resp);
    check_data("returning_data_o", resp, model_mem[5]);
    run_active = 1'b0;
    wait_credits_back();

    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
rtl/gs_pkg.sv
rtl/gs_csr.sv
rtl/gs_dmem.sv
rtl/gs_scatter_engine.sv
rtl/gs_tile.sv
verification/gs_tile_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the scatter tile testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module gs_tile_tb -f vlog.f -o gs_tile_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/gs_tile_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TESTBENCH FAILED" "$log"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$log"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
